/* design/rd_rx_ram.sv */
module rd_rx_ram
#(
	parameter int ADDR_W   = 11,
	parameter int PASS_LEN = 64
)
(
	input  logic                     sys_clk,
	input  logic                     glbl_rst_n,
	input  logic                     load_rd_en,
	input  logic                     ack_rd_en,
	input  logic                     pass_rd_en,
	output logic                     rx_buff_rden,
	output logic [ADDR_W-1:0]        rx_buff_rdaddr,
	input  rx_frame_pkg::byte_t      rx_buff_rddata,
	output logic                     rx_data_valid,
	output rx_frame_pkg::byte_t      rx_data,
	output logic                     got_frame,
	output rx_frame_pkg::frame_id_t   frame_id,
	output rx_frame_pkg::frame_type_t frame_type,
	output rx_frame_pkg::frame_sn_t   frame_sn
);

	import rx_frame_pkg::*;
	import rx_buff_pkg::*;

	// Load covers the lead byte, header and one spare
	localparam int LOAD_LEN = 6;
	localparam int MAX_LEN  = (PASS_LEN > ACK_LEN) ? PASS_LEN : ACK_LEN;
	localparam int CNT_W    = $clog2(MAX_LEN + 1);

	rd_mode_t          mode;
	logic [CNT_W-1:0]  rd_cnt;
	logic [CNT_W-1:0]  last_cnt;

	logic              rden_d1;
	logic              load_d1;
	logic              load_d2;
	logic [ADDR_W-1:0] addr_d1;
	logic [ADDR_W-1:0] addr_d2;

	frame_id_t         hdr_id;
	frame_type_t       hdr_type;
	byte_t             hdr_sn_hi;
	byte_t             hdr_sn_lo;

	//////////////////////////////
	// Address sequencer
	//////////////////////////////

	always_comb
	begin
		case (mode)
			MODE_LOAD: last_cnt = CNT_W'(LOAD_LEN - 1);
			MODE_ACK:  last_cnt = CNT_W'(ACK_LEN - 1);
			MODE_PASS: last_cnt = CNT_W'(PASS_LEN - 1);
			default:   last_cnt = '0;
		endcase
	end

	// Pass beats ack, ack beats load
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			mode           <= MODE_IDLE;
			rx_buff_rden   <= 1'b0;
			rx_buff_rdaddr <= '0;
			rd_cnt         <= '0;
		end
		else if (mode == MODE_IDLE)
		begin
			rd_cnt <= '0;
			if (pass_rd_en)
			begin
				mode           <= MODE_PASS;
				rx_buff_rden   <= 1'b1;
				rx_buff_rdaddr <= ADDR_W'(PASS_START);
			end
			else if (ack_rd_en)
			begin
				mode           <= MODE_ACK;
				rx_buff_rden   <= 1'b1;
				rx_buff_rdaddr <= ADDR_W'(ACK_START);
			end
			else if (load_rd_en)
			begin
				mode           <= MODE_LOAD;
				rx_buff_rden   <= 1'b1;
				rx_buff_rdaddr <= '0;
			end
		end
		else if (rd_cnt == last_cnt)
		begin
			mode         <= MODE_IDLE;
			rx_buff_rden <= 1'b0;
		end
		else
		begin
			// Wraps at the buffer depth
			rx_buff_rdaddr <= rx_buff_rdaddr + 1'b1;
			rd_cnt         <= rd_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Stream alignment
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			rden_d1       <= 1'b0;
			rx_data_valid <= 1'b0;
			load_d1       <= 1'b0;
			load_d2       <= 1'b0;
		end
		else
		begin
			rden_d1       <= rx_buff_rden;
			rx_data_valid <= rden_d1;
			load_d1       <= rx_buff_rden && (mode == MODE_LOAD);
			load_d2       <= load_d1;
		end
	end

	// Byte and its address ride along with the valid pipe
	always_ff @(posedge sys_clk)
	begin
		addr_d1 <= rx_buff_rdaddr;
		addr_d2 <= addr_d1;
		rx_data <= rx_buff_rddata;
	end

	//////////////////////////////
	// Header capture
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (load_d2)
		begin
			case (addr_d2)
				ADDR_W'(ID_OFS):    hdr_id    <= rx_data;
				ADDR_W'(TYPE_OFS):  hdr_type  <= rx_data;
				ADDR_W'(SN_HI_OFS): hdr_sn_hi <= rx_data;
				ADDR_W'(SN_LO_OFS): hdr_sn_lo <= rx_data;
				default:            ;
			endcase
		end
	end

	// Publish on the last load byte, fields hold until the next load
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			got_frame  <= 1'b0;
			frame_id   <= '0;
			frame_type <= '0;
			frame_sn   <= '0;
		end
		else
		begin
			got_frame <= load_d2 && (addr_d2 == ADDR_W'(LOAD_LEN - 1));
			if (load_d2 && (addr_d2 == ADDR_W'(LOAD_LEN - 1)))
			begin
				frame_id   <= hdr_id;
				frame_type <= hdr_type;
				frame_sn   <= {hdr_sn_hi, hdr_sn_lo};
			end
		end
	end

endmodule

/* design/rx_buff_pkg.sv */
package rx_buff_pkg;

	// Sequencer state, one per read kind
	typedef enum logic [1:0]
	{
		MODE_IDLE,
		MODE_LOAD,
		MODE_ACK,
		MODE_PASS
	} rd_mode_t;

	//////////////////////////////
	// Read windows
	//////////////////////////////

	// Ack read covers type, sn and following bytes
	localparam int ACK_START = 2;
	localparam int ACK_LEN   = 16;

	// Payload starts right after the sn high byte
	localparam int PASS_START = 4;

endpackage

/* design/rx_buff_ram.sv */
module rx_buff_ram
#(
	parameter int ADDR_W = 11
)
(
	input  logic                sys_clk,
	input  logic                wr_en,
	input  logic [ADDR_W-1:0]   wr_addr,
	input  rx_frame_pkg::byte_t wr_data,
	input  logic                rd_en,
	input  logic [ADDR_W-1:0]   rd_addr,
	output rx_frame_pkg::byte_t rd_data
);

	import rx_frame_pkg::*;

	localparam int DEPTH = 1 << ADDR_W;

	byte_t mem [DEPTH];

	// Write side, one byte per clock
	always_ff @(posedge sys_clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// Registered read, holds while rd_en is low
	always_ff @(posedge sys_clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* design/rx_frame_path.sv */
module rx_frame_path
#(
	parameter int ADDR_W   = 11,
	parameter int PASS_LEN = 64
)
(
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  logic                      buf_wr_en,
	input  logic [ADDR_W-1:0]         buf_wr_addr,
	input  rx_frame_pkg::byte_t       buf_wr_data,
	input  logic                      load_rd_en,
	input  logic                      ack_rd_en,
	input  logic                      pass_rd_en,
	output logic                      rx_data_valid,
	output rx_frame_pkg::byte_t       rx_data,
	output logic                      got_frame,
	output rx_frame_pkg::frame_id_t   frame_id,
	output rx_frame_pkg::frame_type_t frame_type,
	output rx_frame_pkg::frame_sn_t   frame_sn,
	output logic                      result_valid,
	output rx_frame_pkg::frame_kind_t result_kind,
	output rx_frame_pkg::frame_sn_t   result_sn,
	output rx_frame_pkg::sum_t        result_sum
);

	import rx_frame_pkg::*;

	// Buffer read port
	logic              rx_buff_rden;
	logic [ADDR_W-1:0] rx_buff_rdaddr;
	byte_t             rx_buff_rddata;

	// Sum to sorter
	logic              sum_done;
	sum_t              stream_sum;

	//////////////////////////////
	// Receive buffer
	//////////////////////////////

	rx_buff_ram #(
		.ADDR_W (ADDR_W)
	) rx_buff_ram_inst (
		.sys_clk (sys_clk),
		.wr_en   (buf_wr_en),
		.wr_addr (buf_wr_addr),
		.wr_data (buf_wr_data),
		.rd_en   (rx_buff_rden),
		.rd_addr (rx_buff_rdaddr),
		.rd_data (rx_buff_rddata)
	);

	//////////////////////////////
	// Read side
	//////////////////////////////

	rd_rx_ram #(
		.ADDR_W   (ADDR_W),
		.PASS_LEN (PASS_LEN)
	) rd_rx_ram_inst (
		.sys_clk        (sys_clk),
		.glbl_rst_n     (glbl_rst_n),
		.load_rd_en     (load_rd_en),
		.ack_rd_en      (ack_rd_en),
		.pass_rd_en     (pass_rd_en),
		.rx_buff_rden   (rx_buff_rden),
		.rx_buff_rdaddr (rx_buff_rdaddr),
		.rx_buff_rddata (rx_buff_rddata),
		.rx_data_valid  (rx_data_valid),
		.rx_data        (rx_data),
		.got_frame      (got_frame),
		.frame_id       (frame_id),
		.frame_type     (frame_type),
		.frame_sn       (frame_sn)
	);

	rx_sum_check rx_sum_check_inst (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.rx_data_valid (rx_data_valid),
		.rx_data       (rx_data),
		.sum_done      (sum_done),
		.stream_sum    (stream_sum)
	);

	rx_frame_sorter rx_frame_sorter_inst (
		.sys_clk      (sys_clk),
		.glbl_rst_n   (glbl_rst_n),
		.got_frame    (got_frame),
		.frame_type   (frame_type),
		.frame_sn     (frame_sn),
		.sum_done     (sum_done),
		.stream_sum   (stream_sum),
		.result_valid (result_valid),
		.result_kind  (result_kind),
		.result_sn    (result_sn),
		.result_sum   (result_sum)
	);

endmodule

/* design/rx_frame_pkg.sv */
package rx_frame_pkg;

	//////////////////////////////
	// Field types
	//////////////////////////////

	// One byte of the receive buffer
	typedef logic [7:0] byte_t;

	typedef logic [7:0] frame_id_t;
	typedef logic [7:0] frame_type_t;

	// Sequence number, high byte first in the buffer
	typedef logic [15:0] frame_sn_t;

	// Byte total, wraps at 2^16
	typedef logic [15:0] sum_t;

	//////////////////////////////
	// Header layout
	//////////////////////////////

	// Address 0 is the lead byte, read but dropped
	localparam int ID_OFS    = 1;
	localparam int TYPE_OFS  = 2;
	localparam int SN_HI_OFS = 3;
	localparam int SN_LO_OFS = 4;

	// Frame type codes
	localparam frame_type_t TYPE_ACK  = 8'h01;
	localparam frame_type_t TYPE_DATA = 8'h02;

	// Sorter classification
	typedef enum logic [1:0]
	{
		KIND_ACK,
		KIND_DATA,
		KIND_OTHER
	} frame_kind_t;

endpackage

/* design/rx_frame_sorter.sv */
module rx_frame_sorter
(
	input  logic                      sys_clk,
	input  logic                      glbl_rst_n,
	input  logic                      got_frame,
	input  rx_frame_pkg::frame_type_t frame_type,
	input  rx_frame_pkg::frame_sn_t   frame_sn,
	input  logic                      sum_done,
	input  rx_frame_pkg::sum_t        stream_sum,
	output logic                      result_valid,
	output rx_frame_pkg::frame_kind_t result_kind,
	output rx_frame_pkg::frame_sn_t   result_sn,
	output rx_frame_pkg::sum_t        result_sum
);

	import rx_frame_pkg::*;

	frame_kind_t kind_q;
	frame_sn_t   sn_q;

	function automatic frame_kind_t kind_of(frame_type_t t);
		case (t)
			TYPE_ACK:  return KIND_ACK;
			TYPE_DATA: return KIND_DATA;
			default:   return KIND_OTHER;
		endcase
	endfunction

	// Last header seen, unknown until the first load
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			kind_q <= KIND_OTHER;
			sn_q   <= '0;
		end
		else if (got_frame)
		begin
			kind_q <= kind_of(frame_type);
			sn_q   <= frame_sn;
		end
	end

	//////////////////////////////
	// Result output
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			result_valid <= 1'b0;
		end
		else
		begin
			result_valid <= sum_done;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (sum_done)
		begin
			result_kind <= kind_q;
			result_sn   <= sn_q;
			result_sum  <= stream_sum;
		end
	end

endmodule

/* design/rx_sum_check.sv */
module rx_sum_check
(
	input  logic                sys_clk,
	input  logic                glbl_rst_n,
	input  logic                rx_data_valid,
	input  rx_frame_pkg::byte_t rx_data,
	output logic                sum_done,
	output rx_frame_pkg::sum_t  stream_sum
);

	import rx_frame_pkg::*;

	logic valid_d;
	sum_t acc;

	// Valid history for edge detect
	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			valid_d <= 1'b0;
		end
		else
		begin
			valid_d <= rx_data_valid;
		end
	end

	// First byte of a read restarts the total
	always_ff @(posedge sys_clk)
	begin
		if (rx_data_valid)
		begin
			acc <= (valid_d ? acc : '0) + sum_t'(rx_data);
		end
	end

	//////////////////////////////
	// End of read
	//////////////////////////////

	always_ff @(posedge sys_clk)
	begin
		if (!glbl_rst_n)
		begin
			sum_done <= 1'b0;
		end
		else
		begin
			sum_done <= valid_d && !rx_data_valid;
		end
	end

	always_ff @(posedge sys_clk)
	begin
		if (valid_d && !rx_data_valid)
		begin
			stream_sum <= acc;
		end
	end

endmodule

/* rx_frame_path.f */
design/rx_frame_pkg.sv
design/rx_buff_pkg.sv
design/rx_buff_ram.sv
design/rd_rx_ram.sv
design/rx_sum_check.sv
design/rx_frame_sorter.sv
design/rx_frame_path.sv
tests/rx_frame_path_properties.sv
tests/rx_frame_path_tb.sv

/* tests/rx_frame_path_properties.sv */
module rx_frame_path_properties
(
	input logic                  sys_clk,
	input logic                  glbl_rst_n,
	input logic                  rx_buff_rden,
	input logic                  rx_data_valid,
	input logic                  got_frame,
	input rx_buff_pkg::rd_mode_t mode
);

	timeunit 1ns;
	timeprecision 100ps;

	import rx_buff_pkg::*;

	// Failed assertions so far
	int fail_cnt = 0;

	//////////////////////////////
	// Sequencer output rules
	//////////////////////////////

	// Header strobe is a single pulse
	got_frame_one_cycle: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		got_frame |=> !got_frame)
	else
	begin
		$error("got_frame stayed high for more than one cycle");
		fail_cnt++;
	end

	// Buffer latency plus the output register, once two cycles out of reset
	valid_follows_rden: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		$past(glbl_rst_n, 2) |-> rx_data_valid == $past(rx_buff_rden, 2))
	else
	begin
		$error("rx_data_valid is not rden delayed by two cycles");
		fail_cnt++;
	end

	no_read_when_idle: assert property (@(posedge sys_clk) disable iff (!glbl_rst_n)
		(mode == MODE_IDLE) |-> !rx_buff_rden)
	else
	begin
		$error("rden high while the sequencer is idle");
		fail_cnt++;
	end

endmodule

/* tests/rx_frame_path_tb.sv */
module rx_frame_path_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import rx_frame_pkg::*;
	import rx_buff_pkg::*;

	localparam int ADDR_W    = 11;
	localparam int DEPTH     = 1 << ADDR_W;
	localparam int NUM_READS = 8;

	logic              sys_clk;
	logic              glbl_rst_n;
	logic              buf_wr_en;
	logic [ADDR_W-1:0] buf_wr_addr;
	byte_t             buf_wr_data;
	logic              load_rd_en;
	logic              ack_rd_en;
	logic              pass_rd_en;
	logic              rx_data_valid;
	byte_t             rx_data;
	logic              got_frame;
	frame_id_t         frame_id;
	frame_type_t       frame_type;
	frame_sn_t         frame_sn;
	logic              result_valid;
	frame_kind_t       result_kind;
	frame_sn_t         result_sn;
	sum_t              result_sum;

	// Model of the buffer contents
	byte_t       model_mem [DEPTH];
	logic [31:0] lcg_state = 32'd85972;
	int          pass_len;
	int          cycle_cnt;
	int          cycle_limit;
	int          error_cnt;
	int          tests_run;
	int          tests_failed;
	int          results_seen;
	frame_kind_t last_kind = KIND_OTHER;
	frame_sn_t   last_sn = '0;

	// Pending expectations, consumed by the compare process
	byte_t       want_bytes [$];
	frame_id_t   want_id [$];
	frame_type_t want_type [$];
	frame_sn_t   want_sn [$];
	frame_kind_t want_kind [$];
	frame_sn_t   want_rsn [$];
	sum_t        want_sum [$];

	rx_frame_path #(
		.ADDR_W (ADDR_W)
	) rx_frame_path_inst (
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.buf_wr_en     (buf_wr_en),
		.buf_wr_addr   (buf_wr_addr),
		.buf_wr_data   (buf_wr_data),
		.load_rd_en    (load_rd_en),
		.ack_rd_en     (ack_rd_en),
		.pass_rd_en    (pass_rd_en),
		.rx_data_valid (rx_data_valid),
		.rx_data       (rx_data),
		.got_frame     (got_frame),
		.frame_id      (frame_id),
		.frame_type    (frame_type),
		.frame_sn      (frame_sn),
		.result_valid  (result_valid),
		.result_kind   (result_kind),
		.result_sn     (result_sn),
		.result_sum    (result_sum)
	);

	bind rd_rx_ram rx_frame_path_properties rx_frame_path_properties_inst
	(
		.sys_clk       (sys_clk),
		.glbl_rst_n    (glbl_rst_n),
		.rx_buff_rden  (rx_buff_rden),
		.rx_data_valid (rx_data_valid),
		.got_frame     (got_frame),
		.mode          (mode)
	);

	initial
	begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic frame_kind_t kind_for_type(input frame_type_t code);
		if (code == TYPE_ACK)
			return KIND_ACK;
		if (code == TYPE_DATA)
			return KIND_DATA;
		return KIND_OTHER;
	endfunction

	// Bytes, header and sum that a read of this mode must give
	function automatic void predict_read(input rd_mode_t mode, output byte_t bytes[$],
		output frame_id_t id, output frame_type_t code, output frame_sn_t sn,
		output sum_t sum);
		int start;
		int len;
		start = 0;
		len   = 6;
		if (mode == MODE_ACK)
		begin
			start = ACK_START;
			len   = ACK_LEN;
		end
		else if (mode == MODE_PASS)
		begin
			start = PASS_START;
			len   = pass_len;
		end
		bytes = {};
		sum   = '0;
		for (int i = 0; i < len; i++)
		begin
			bytes.push_back(model_mem[(start + i) % DEPTH]);
			sum = sum + sum_t'(model_mem[(start + i) % DEPTH]);
		end
		id   = model_mem[ID_OFS];
		code = model_mem[TYPE_OFS];
		sn   = {model_mem[SN_HI_OFS], model_mem[SN_LO_OFS]};
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			error_cnt++;
		end
	endtask

	task automatic check_byte(input byte_t got, input byte_t exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t: stream byte %h, expected %h", $time, got, exp);
			error_cnt++;
		end
	endtask

	task automatic check_header(input frame_id_t got_id, input frame_id_t exp_id,
		input frame_type_t got_type, input frame_type_t exp_type,
		input frame_sn_t got_sn, input frame_sn_t exp_sn);
		if (got_id !== exp_id || got_type !== exp_type || got_sn !== exp_sn)
		begin
			$display("FAILED at %0t: header %h/%h/%h, expected %h/%h/%h", $time,
				got_id, got_type, got_sn, exp_id, exp_type, exp_sn);
			error_cnt++;
		end
	endtask

	task automatic check_result(input frame_kind_t got_kind, input frame_kind_t exp_kind,
		input frame_sn_t got_sn, input frame_sn_t exp_sn,
		input sum_t got_sum, input sum_t exp_sum);
		if (got_kind !== exp_kind || got_sn !== exp_sn || got_sum !== exp_sum)
		begin
			$display("FAILED at %0t: result kind %0d sn %h sum %h, expected %0d %h %h",
				$time, got_kind, got_sn, got_sum, exp_kind, exp_sn, exp_sum);
			error_cnt++;
		end
	endtask

	// Compare process, DUT outputs sampled at the rising edge
	always @(posedge sys_clk)
	begin
		if (rx_data_valid)
		begin
			if (want_bytes.size() == 0)
			begin
				$display("Unexpected byte %h on the stream at %0t", rx_data, $time);
				error_cnt++;
			end
			else
				check_byte(rx_data, want_bytes.pop_front());
		end
		if (got_frame)
		begin
			if (want_id.size() == 0)
			begin
				$display("Unexpected got_frame pulse at %0t", $time);
				error_cnt++;
			end
			else
				check_header(frame_id, want_id.pop_front(), frame_type,
					want_type.pop_front(), frame_sn, want_sn.pop_front());
		end
		if (result_valid)
		begin
			results_seen++;
			if (want_kind.size() == 0)
			begin
				$display("Unexpected result pulse at %0t", $time);
				error_cnt++;
			end
			else
				check_result(result_kind, want_kind.pop_front(), result_sn,
					want_rsn.pop_front(), result_sum, want_sum.pop_front());
		end
	end

	always @(posedge sys_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit)
		begin
			$display("Timeout after %0d cycles, a read never completed", cycle_cnt);
			$display("TEST FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus tasks
	//////////////////////////////

	task automatic write_byte(input int addr, input byte_t data);
		@(negedge sys_clk);
		buf_wr_en       = 1'b1;
		buf_wr_addr     = ADDR_W'(addr);
		buf_wr_data     = data;
		model_mem[addr] = data;
	endtask

	task automatic end_writes();
		@(negedge sys_clk);
		buf_wr_en = 1'b0;
	endtask

	task automatic fill_buffer();
		for (int a = 0; a < DEPTH; a++)
		begin
			lcg_state = lcg_next(lcg_state);
			write_byte(a, lcg_state[23:16]);
		end
		end_writes();
	endtask

	task automatic send_request(input logic load, input logic ack, input logic pass);
		@(negedge sys_clk);
		load_rd_en = load;
		ack_rd_en  = ack;
		pass_rd_en = pass;
		@(negedge sys_clk);
		load_rd_en = 1'b0;
		ack_rd_en  = 1'b0;
		pass_rd_en = 1'b0;
	endtask

	task automatic check_reset_state();
		repeat (3)
		begin
			@(negedge sys_clk);
			check_level(rx_data_valid, 1'b0, "rx_data_valid");
			check_level(got_frame, 1'b0, "got_frame");
			check_level(result_valid, 1'b0, "result_valid");
			check_header(frame_id, '0, frame_type, '0, frame_sn, '0);
		end
	endtask

	// One read with its expectations, poke_busy adds a request mid-read
	task automatic run_read(input rd_mode_t mode, input logic load, input logic ack,
		input logic pass, input bit poke_busy);
		byte_t       bytes [$];
		frame_id_t   id;
		frame_type_t code;
		frame_sn_t   sn;
		sum_t        sum;
		int          target;
		predict_read(mode, bytes, id, code, sn, sum);
		foreach (bytes[i])
			want_bytes.push_back(bytes[i]);
		if (mode == MODE_LOAD)
		begin
			want_id.push_back(id);
			want_type.push_back(code);
			want_sn.push_back(sn);
			last_kind = kind_for_type(code);
			last_sn   = sn;
		end
		want_kind.push_back(last_kind);
		want_rsn.push_back(last_sn);
		want_sum.push_back(sum);
		target = results_seen + 1;
		send_request(load, ack, pass);
		if (poke_busy)
		begin
			repeat (pass_len / 2) @(negedge sys_clk);
			send_request(1'b1, 1'b1, 1'b0);
		end
		while (results_seen < target)
			@(negedge sys_clk);
		if (poke_busy)
			repeat (pass_len + 8) @(negedge sys_clk);
		if (want_bytes.size() != 0 || want_id.size() != 0 || want_kind.size() != 0)
		begin
			$display("Read ended with %0d bytes and %0d headers still missing",
				want_bytes.size(), want_id.size());
			error_cnt++;
			want_bytes = {};
			want_id    = {};
			want_type  = {};
			want_sn    = {};
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (error_cnt != errs_before)
		begin
			tests_failed++;
			$display("%s: %0d errors", name, error_cnt - errs_before);
		end
		else
			$display("%s: ok", name);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		int errs;
		pass_len    = rx_frame_path_inst.PASS_LEN;
		cycle_limit = DEPTH + 16 + (pass_len + 30) * NUM_READS;
		glbl_rst_n  = 1'b0;
		buf_wr_en   = 1'b0;
		buf_wr_addr = '0;
		buf_wr_data = '0;
		load_rd_en  = 1'b0;
		ack_rd_en   = 1'b0;
		pass_rd_en  = 1'b0;
		repeat (2) @(negedge sys_clk);
		glbl_rst_n = 1'b1;

		errs = error_cnt;
		check_reset_state();
		finish_test("reset state", errs);

		fill_buffer();

		// Same header, three type codes, data last so later results differ from reset
		errs = error_cnt;
		write_byte(TYPE_OFS, TYPE_ACK);
		end_writes();
		run_read(MODE_LOAD, 1'b1, 1'b0, 1'b0, 1'b0);
		write_byte(TYPE_OFS, 8'h5a);
		end_writes();
		run_read(MODE_LOAD, 1'b1, 1'b0, 1'b0, 1'b0);
		write_byte(TYPE_OFS, TYPE_DATA);
		end_writes();
		run_read(MODE_LOAD, 1'b1, 1'b0, 1'b0, 1'b0);
		finish_test("header load", errs);

		errs = error_cnt;
		run_read(MODE_ACK, 1'b0, 1'b1, 1'b0, 1'b0);
		finish_test("ack read", errs);

		errs = error_cnt;
		run_read(MODE_PASS, 1'b0, 1'b0, 1'b1, 1'b0);
		finish_test("payload pass", errs);

		errs = error_cnt;
		run_read(MODE_PASS, 1'b0, 1'b0, 1'b1, 1'b1);
		finish_test("request while busy", errs);

		errs = error_cnt;
		run_read(MODE_ACK, 1'b1, 1'b1, 1'b0, 1'b0);
		finish_test("ack over load", errs);

		error_cnt += rx_frame_path_inst.rd_rx_ram_inst.rx_frame_path_properties_inst.fail_cnt;
		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, error_cnt);
		if (error_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule
